// File: hdl/clk_reconfig_top.sv
`default_nettype none

module clk_reconfig_top
   import reconfig_pkg::*;
#(
   parameter  int N_OUT   = 4,
   localparam int N_STEPS = 2 * N_OUT + 4,
   localparam int STEP_W  = $clog2(N_STEPS)
) (
   input  wire                           dclk,
   input  wire                           rst,
   input  wire                           start_reconfig,
   input  wire  [N_OUT-1:0][DIV_W-1:0]   out_div,
   input  wire  [N_OUT-1:0][PHASE_W-1:0] out_phase,
   input  wire  [N_OUT-1:0][TIME_W-1:0]  out_delay,
   input  wire  [DIV_W-1:0]              fb_div,
   input  wire  [PHASE_W-1:0]            fb_phase,
   input  wire  [TIME_W-1:0]             fb_delay,
   input  wire  [DIV_W-1:0]              in_div,
   input  wire  [DRP_DW-1:0]             dout,
   input  wire                           drdy,
   input  wire                           locked,
   output logic                          ready,
   output logic                          reconfig_done,
   output logic [DRP_AW-1:0]             daddr,
   output logic [DRP_DW-1:0]             din,
   output logic                          den,
   output logic                          dwe,
   output logic                          rst_mmcm
);

   logic [STEP_W-1:0]             step;
   logic [N_OUT+1:0][DIV_W-1:0]   cnt_div;
   logic [N_OUT+1:0][PHASE_W-1:0] cnt_phase;
   logic [N_OUT+1:0][TIME_W-1:0]  cnt_delay;
   counter_word_u [N_OUT+1:0]     reg1_words;
   counter_word_u [N_OUT+1:0]     reg2_words;
   logic [DRP_AW-1:0]             step_addr;
   logic [DRP_DW-1:0]             step_mask;
   logic [DRP_DW-1:0]             step_data;

   drp_sequencer #(.N_OUT(N_OUT)) seq_i (
      .dclk, .rst, .start_reconfig,
      .out_div, .out_phase, .out_delay,
      .fb_div, .fb_phase, .fb_delay, .in_div,
      .dout, .drdy, .locked,
      .step_addr, .step_mask, .step_data,
      .ready, .reconfig_done,
      .daddr, .din, .den, .dwe, .rst_mmcm,
      .step, .cnt_div, .cnt_phase, .cnt_delay
   );

   // Outputs, then feedback, then input divider
   for (genvar i = 0; i < N_OUT + 2; i++) begin : g_enc
      counter_encoder enc_i (
         .div       (cnt_div[i]),
         .phase     (cnt_phase[i]),
         .delay     (cnt_delay[i]),
         .reg1_word (reg1_words[i]),
         .reg2_word (reg2_words[i])
      );
   end

   drp_step_table #(.N_OUT(N_OUT)) table_i (
      .step,
      .reg1_words,
      .reg2_words,
      .step_addr,
      .step_mask,
      .step_data
   );

endmodule

`default_nettype wire

// File: hdl/counter_encoder.sv
`default_nettype none

module counter_encoder
   import reconfig_pkg::*;
(
   input  wire [DIV_W-1:0]   div,
   input  wire [PHASE_W-1:0] phase,
   input  wire [TIME_W-1:0]  delay,
   output counter_word_u     reg1_word,
   output counter_word_u     reg2_word
);

   logic             single;
   logic [DIV_W-1:0] high_t;
   logic [DIV_W-1:0] low_t;

   assign single = (div == DIV_W'(1));

   // 50 % duty split with the extra cycle of odd ratios in low time
   assign high_t = single ? DIV_W'(1) : {1'b0, div[DIV_W-1:1]};
   assign low_t  = single ? DIV_W'(1) : div - high_t;

   always_comb begin
      reg1_word = '0;
      reg2_word = '0;

      reg1_word.reg1.phase = phase;
      reg1_word.reg1.high  = high_t[TIME_W-1:0];   // 64 wraps to 0
      reg1_word.reg1.low   = low_t[TIME_W-1:0];

      reg2_word.reg2.edge_bit = div[0];
      reg2_word.reg2.no_count = single;
      reg2_word.reg2.delay    = delay;
   end

endmodule

`default_nettype wire

// File: hdl/drp_sequencer.sv
`default_nettype none

module drp_sequencer
   import reconfig_pkg::*;
#(
   parameter  int N_OUT   = 4,
   localparam int N_STEPS = 2 * N_OUT + 4,
   localparam int STEP_W  = $clog2(N_STEPS)
) (
   input  wire                           dclk,
   input  wire                           rst,
   input  wire                           start_reconfig,
   input  wire  [N_OUT-1:0][DIV_W-1:0]   out_div,
   input  wire  [N_OUT-1:0][PHASE_W-1:0] out_phase,
   input  wire  [N_OUT-1:0][TIME_W-1:0]  out_delay,
   input  wire  [DIV_W-1:0]              fb_div,
   input  wire  [PHASE_W-1:0]            fb_phase,
   input  wire  [TIME_W-1:0]             fb_delay,
   input  wire  [DIV_W-1:0]              in_div,
   input  wire  [DRP_DW-1:0]             dout,
   input  wire                           drdy,
   input  wire                           locked,
   input  wire  [DRP_AW-1:0]             step_addr,
   input  wire  [DRP_DW-1:0]             step_mask,
   input  wire  [DRP_DW-1:0]             step_data,
   output logic                          ready,
   output logic                          reconfig_done,
   output logic [DRP_AW-1:0]             daddr,
   output logic [DRP_DW-1:0]             din,
   output logic                          den,
   output logic                          dwe,
   output logic                          rst_mmcm,
   output logic [STEP_W-1:0]             step,
   output logic [N_OUT+1:0][DIV_W-1:0]   cnt_div,
   output logic [N_OUT+1:0][PHASE_W-1:0] cnt_phase,
   output logic [N_OUT+1:0][TIME_W-1:0]  cnt_delay
);

   localparam logic [3:0] S_RESTART    = 4'd0;
   localparam logic [3:0] S_WAIT_LOCK  = 4'd1;
   localparam logic [3:0] S_WAIT_START = 4'd2;
   localparam logic [3:0] S_ADDRESS    = 4'd3;
   localparam logic [3:0] S_WAIT_READ  = 4'd4;
   localparam logic [3:0] S_MASK       = 4'd5;
   localparam logic [3:0] S_SET        = 4'd6;
   localparam logic [3:0] S_WRITE      = 4'd7;
   localparam logic [3:0] S_WAIT_WRITE = 4'd8;

   logic [3:0] state;
   logic       last_step;
   logic       accept;

   assign last_step     = (step == STEP_W'(N_STEPS - 1));
   assign ready         = (state == S_WAIT_START);
   assign accept        = ready && start_reconfig;
   assign reconfig_done = (state == S_WAIT_WRITE) && drdy && last_step;

   always_ff @(posedge dclk) begin
      if (rst) begin
         state    <= S_RESTART;
         step     <= '0;
         den      <= 1'b0;
         dwe      <= 1'b0;
         rst_mmcm <= 1'b0;
      end else begin
         den <= 1'b0;   // Strobes last one cycle
         dwe <= 1'b0;
         case (state)
            S_RESTART: begin
               rst_mmcm <= 1'b1;
               state    <= S_WAIT_LOCK;
            end
            S_WAIT_LOCK: begin
               rst_mmcm <= 1'b0;
               step     <= '0;
               // A lock seen while the tile is still in reset is stale
               if (locked && !rst_mmcm)
                  state <= S_WAIT_START;
            end
            S_WAIT_START: begin
               if (accept)
                  state <= S_ADDRESS;
            end
            S_ADDRESS: begin
               rst_mmcm <= 1'b1;   // Tile held in reset until the last write
               den      <= 1'b1;
               state    <= S_WAIT_READ;
            end
            S_WAIT_READ: begin
               if (drdy)
                  state <= S_MASK;
            end
            S_MASK: state <= S_SET;
            S_SET: begin
               den   <= 1'b1;
               dwe   <= 1'b1;
               state <= S_WRITE;
            end
            S_WRITE: state <= S_WAIT_WRITE;
            S_WAIT_WRITE: begin
               if (drdy && last_step) begin
                  rst_mmcm <= 1'b0;
                  state    <= S_WAIT_LOCK;
               end else if (drdy) begin
                  step  <= step + STEP_W'(1);
                  state <= S_ADDRESS;
               end
            end
            default: state <= S_RESTART;
         endcase
      end
   end

   // Settings snapshot and port data
   always_ff @(posedge dclk) begin
      if (accept) begin
         cnt_div   <= {in_div, fb_div, out_div};
         cnt_phase <= {PHASE_W'(0), fb_phase, out_phase};   // No phase on input divider
         cnt_delay <= {TIME_W'(0), fb_delay, out_delay};
      end
      case (state)
         S_ADDRESS:   daddr <= step_addr;
         S_WAIT_READ: if (drdy) din <= dout;
         S_MASK:      din <= din & step_mask;
         S_SET:       din <= din | step_data;
         default:     din <= din;
      endcase
   end

endmodule

`default_nettype wire

// File: hdl/drp_step_table.sv
`default_nettype none

module drp_step_table
   import reconfig_pkg::*;
#(
   parameter  int N_OUT   = 4,
   localparam int N_STEPS = 2 * N_OUT + 4,
   localparam int STEP_W  = $clog2(N_STEPS)
) (
   input  wire [STEP_W-1:0]               step,
   input  wire counter_word_u [N_OUT+1:0] reg1_words,
   input  wire counter_word_u [N_OUT+1:0] reg2_words,
   output logic [DRP_AW-1:0]              step_addr,
   output logic [DRP_DW-1:0]              step_mask,
   output logic [DRP_DW-1:0]              step_data
);

   localparam int FB_IDX   = N_OUT;
   localparam int IN_IDX   = N_OUT + 1;
   localparam int DIV_STEP = 2 * N_OUT + 1;

   logic [STEP_W-1:0] out_idx;
   logic [DRP_DW-1:0] divclk_word;

   // Steps 1 and 2 are CLKOUT0, 3 and 4 CLKOUT1 and so on
   assign out_idx = (step - STEP_W'(1)) >> 1;

   // Input divider takes both halves in one register
   assign divclk_word = {2'b00,
                         reg2_words[IN_IDX].reg2.edge_bit,
                         reg2_words[IN_IDX].reg2.no_count,
                         reg1_words[IN_IDX].reg1.high,
                         reg1_words[IN_IDX].reg1.low};

   always_comb begin
      // Step 0 and anything past the end
      step_addr = POWER_ADDR;
      step_mask = POWER_MASK;
      step_data = POWER_DATA;

      if (step >= STEP_W'(1) && step <= STEP_W'(2 * N_OUT)) begin
         if (step[0]) begin
            step_addr = CLKOUT_REG1_ADDR[out_idx];
            step_mask = REG1_MASK;
            step_data = reg1_words[out_idx];
         end else begin
            step_addr = CLKOUT_REG2_ADDR[out_idx];
            step_mask = REG2_MASK;
            step_data = reg2_words[out_idx];
         end
      end else if (step == STEP_W'(DIV_STEP)) begin
         step_addr = DIVCLK_ADDR;
         step_mask = DIVCLK_MASK;
         step_data = divclk_word;
      end else if (step == STEP_W'(DIV_STEP + 1)) begin
         step_addr = FB_REG1_ADDR;
         step_mask = REG1_MASK;
         step_data = reg1_words[FB_IDX];
      end else if (step == STEP_W'(DIV_STEP + 2)) begin
         step_addr = FB_REG2_ADDR;
         step_mask = REG2_MASK;
         step_data = reg2_words[FB_IDX];
      end
   end

endmodule

`default_nettype wire

// File: hdl/reconfig_pkg.sv
`default_nettype none

package reconfig_pkg;

   localparam int DRP_DW  = 16;
   localparam int DRP_AW  = 7;
   localparam int DIV_W   = 7;   // Ratio 1 to 64
   localparam int TIME_W  = 6;
   localparam int PHASE_W = 3;
   localparam int MAX_OUT = 7;

   // Element 0 is CLKOUT0
   localparam logic [MAX_OUT-1:0][DRP_AW-1:0] CLKOUT_REG1_ADDR =
      {7'h12, 7'h06, 7'h10, 7'h0E, 7'h0C, 7'h0A, 7'h08};
   localparam logic [MAX_OUT-1:0][DRP_AW-1:0] CLKOUT_REG2_ADDR =
      {7'h13, 7'h07, 7'h11, 7'h0F, 7'h0D, 7'h0B, 7'h09};

   localparam logic [DRP_AW-1:0] FB_REG1_ADDR = 7'h14;
   localparam logic [DRP_AW-1:0] FB_REG2_ADDR = 7'h15;
   localparam logic [DRP_AW-1:0] DIVCLK_ADDR  = 7'h16;
   localparam logic [DRP_AW-1:0] POWER_ADDR   = 7'h28;

   // Bits set here survive the read-modify-write
   localparam logic [DRP_DW-1:0] REG1_MASK   = 16'h1000;
   localparam logic [DRP_DW-1:0] REG2_MASK   = 16'hFC00;
   localparam logic [DRP_DW-1:0] DIVCLK_MASK = 16'hC000;
   localparam logic [DRP_DW-1:0] POWER_MASK  = 16'h0000;
   localparam logic [DRP_DW-1:0] POWER_DATA  = 16'hFFFF;

   typedef union packed {
      struct packed {
         logic [PHASE_W-1:0] phase;
         logic               rsvd;
         logic [TIME_W-1:0]  high;
         logic [TIME_W-1:0]  low;
      } reg1;
      struct packed {
         logic [5:0]         rsvd_hi;
         logic [1:0]         rsvd_lo;
         logic               edge_bit;   // Odd ratio
         logic               no_count;   // Bypass for divide by 1
         logic [TIME_W-1:0]  delay;
      } reg2;
   } counter_word_u;

endpackage

`default_nettype wire

// File: verif/drp_port_asserts.sv
`default_nettype none

module drp_port_asserts (
   input wire dclk,
   input wire rst,
   input wire den,
   input wire dwe,
   input wire drdy,
   input wire ready,
   input wire rst_mmcm
);

   int   fail_cnt = 0;
   logic pending;   // Request out with drdy not yet back

   function automatic void note_failure(string what);
      $error("%s", what);
      fail_cnt++;
   endfunction

   always @(posedge dclk) begin
      if (rst)
         pending <= 1'b0;
      else if (den)
         pending <= 1'b1;
      else if (drdy)
         pending <= 1'b0;
   end

   assert property (@(posedge dclk) disable iff (rst) den |=> !den)
      else note_failure("den high for more than one cycle");
   assert property (@(posedge dclk) disable iff (rst) dwe |-> den)
      else note_failure("dwe high without den");
   assert property (@(posedge dclk) disable iff (rst) den |-> !pending)
      else note_failure("second den issued before drdy");
   assert property (@(posedge dclk) disable iff (rst) rst_mmcm |-> !ready)
      else note_failure("ready high while the tile is in reset");

endmodule

`default_nettype wire

// File: verif/drp_tile_model.sv
`default_nettype none

module drp_tile_model #(
   parameter int LOCK_CYC = 12
) (
   input  wire         dclk,
   input  wire         rst,
   input  wire  [6:0]  daddr,
   input  wire  [15:0] din,
   input  wire         den,
   input  wire         dwe,
   input  wire         rst_mmcm,
   output logic [15:0] dout,
   output logic        drdy,
   output logic        locked
);

   logic [15:0] mem [128];
   logic [6:0]  addr_q;
   logic [15:0] data_q;
   logic        we_q;
   logic        busy;
   int          wait_cnt;
   int          lock_cnt;

   initial begin
      dout   = '0;
      drdy   = 1'b0;
      locked = 1'b0;
   end

   // Random contents drawn in the caller's process
   task automatic preload();
      for (int a = 0; a < 128; a++)
         mem[a] = 16'($urandom);
   endtask

   always @(posedge dclk) begin
      drdy <= 1'b0;
      if (rst) begin
         busy <= 1'b0;
      end else if (den) begin
         busy     <= 1'b1;
         wait_cnt <= $urandom_range(5, 0);   // drdy 1 to 6 cycles after den
         addr_q   <= daddr;
         data_q   <= din;
         we_q     <= dwe;
      end else if (busy && wait_cnt == 0) begin
         busy <= 1'b0;
         drdy <= 1'b1;
         dout <= mem[addr_q];
         if (we_q)
            mem[addr_q] <= data_q;
      end else if (busy) begin
         wait_cnt <= wait_cnt - 1;
      end
   end

   // Lock returns a while after the tile leaves reset
   always @(posedge dclk) begin
      if (rst || rst_mmcm) begin
         lock_cnt <= 0;
         locked   <= 1'b0;
      end else if (lock_cnt < LOCK_CYC) begin
         lock_cnt <= lock_cnt + 1;
      end else begin
         locked <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: verif/tb_clk_reconfig.sv
`default_nettype none

module tb_clk_reconfig;

   localparam int N_OUT   = 4;
   localparam int N_REGS  = 2 * N_OUT + 4;
   localparam int MAX_CYC = 3 * N_REGS * 20 + 200;

   logic                  dclk;
   logic                  rst;
   logic                  start_reconfig;
   logic [N_OUT-1:0][6:0] out_div;
   logic [N_OUT-1:0][2:0] out_phase;
   logic [N_OUT-1:0][5:0] out_delay;
   logic [6:0]            fb_div;
   logic [2:0]            fb_phase;
   logic [5:0]            fb_delay;
   logic [6:0]            in_div;
   logic [15:0]           dout;
   logic [15:0]           din;
   logic [6:0]            daddr;
   logic                  drdy, locked, ready, reconfig_done, den, dwe, rst_mmcm;
   int                    cycles = 0;
   int                    dones;
   int                    div_s [N_OUT+2];   // N_OUT is feedback, N_OUT+1 input divider
   int                    phase_s [N_OUT+2];
   int                    delay_s [N_OUT+2];
   logic [6:0]            exp_addr [N_REGS];
   logic [15:0]           exp_val [N_REGS];
   string                 exp_name [N_REGS];

   bind clk_reconfig_top drp_port_asserts port_chk_i (.*);

   clk_reconfig_top #(.N_OUT(N_OUT)) dut_i (.*);
   drp_tile_model tile_i (.*);

   initial begin
      dclk = 1'b0;
      forever #4 dclk = ~dclk;
   end

   task automatic fail_stop(string why);
      $display("%s", why);
      $display("Test failures found");
      $fatal(1);
   endtask

   task automatic report_mismatch(string name, int expected, int actual);
      fail_stop($sformatf("error: %s expected %0h actual %0h", name, expected, actual));
   endtask

   function automatic int high_time(int div);
      return (div == 1) ? 1 : div / 2;
   endfunction

   function automatic logic [15:0] reg1_word(int div, int phase);
      int low = (div == 1) ? 1 : div - high_time(div);
      return 16'((phase << 13) | ((high_time(div) % 64) << 6) | (low % 64));
   endfunction

   function automatic logic [15:0] reg2_word(int div, int delay);
      return 16'(((div % 2) << 7) | ((div == 1) ? 64 : 0) | delay);
   endfunction

   task automatic expect_reg(int k, string name, int addr, logic [15:0] mask,
                             logic [15:0] word);
      exp_name[k] = name;
      exp_addr[k] = 7'(addr);
      exp_val[k]  = (tile_i.mem[addr] & mask) | word;
   endtask

   task automatic build_expect();
      expect_reg(0, "power", 'h28, 16'h0000, 16'hFFFF);
      for (int i = 0; i < N_OUT; i++) begin
         expect_reg(2 * i + 1, $sformatf("clkout%0d reg1", i), 'h08 + 2 * i, 16'h1000,
                    reg1_word(div_s[i], phase_s[i]));   // 08, 0A, 0C, 0E
         expect_reg(2 * i + 2, $sformatf("clkout%0d reg2", i), 'h09 + 2 * i, 16'hFC00,
                    reg2_word(div_s[i], delay_s[i]));
      end
      // Edge and no-count sit just above high and low
      expect_reg(2 * N_OUT + 1, "divclk", 'h16, 16'hC000,
                 16'(reg2_word(div_s[N_OUT+1], 0) << 6) | reg1_word(div_s[N_OUT+1], 0));
      expect_reg(2 * N_OUT + 2, "fb reg1", 'h14, 16'h1000,
                 reg1_word(div_s[N_OUT], phase_s[N_OUT]));
      expect_reg(2 * N_OUT + 3, "fb reg2", 'h15, 16'hFC00,
                 reg2_word(div_s[N_OUT], delay_s[N_OUT]));
   endtask

   task automatic pick_settings(bit corners);
      for (int i = 0; i < N_OUT + 2; i++) begin
         div_s[i]   = $urandom_range(64, 1);
         phase_s[i] = $urandom_range(7, 0);
         delay_s[i] = $urandom_range(63, 0);
      end
      if (corners) begin
         div_s[0] = 1;
         div_s[1] = 2;
         div_s[2] = 7;
         div_s[3] = 64;
      end
      for (int i = 0; i < N_OUT; i++) begin
         out_div[i]   = 7'(div_s[i]);
         out_phase[i] = 3'(phase_s[i]);
         out_delay[i] = 6'(delay_s[i]);
      end
      fb_div   = 7'(div_s[N_OUT]);
      fb_phase = 3'(phase_s[N_OUT]);
      fb_delay = 6'(delay_s[N_OUT]);
      in_div   = 7'(div_s[N_OUT+1]);
   endtask

   // Runs until ready is seen and counts done pulses on the way
   task automatic wait_ready();
      logic lock_prev;
      lock_prev = 1'b0;
      dones     = 0;
      @(posedge dclk);
      while (!ready) begin
         lock_prev = locked;
         dones += int'(reconfig_done);
         @(posedge dclk);
      end
      assert (lock_prev) else fail_stop("ready rose without locked high the cycle before");
   endtask

   initial begin
      void'($urandom(38));
      rst            = 1'b1;
      start_reconfig = 1'b0;
      pick_settings(1'b0);
      tile_i.preload();
      repeat (8) @(posedge dclk);
      #1 rst = 1'b0;
      @(posedge dclk);
      while (!rst_mmcm)
         @(posedge dclk);
      @(posedge dclk);
      assert (!rst_mmcm) else fail_stop("rst_mmcm stayed high after the post-reset pulse");
      wait_ready();
      for (int run = 0; run < 3; run++) begin
         #1 pick_settings(run == 0);
         start_reconfig = 1'b1;
         @(posedge dclk);   // Accepted here
         build_expect();
         #1 start_reconfig = 1'b0;
         pick_settings(1'b0);   // Late changes that the snapshot must ignore
         wait_ready();
         assert (dones == 1)
            else report_mismatch($sformatf("run%0d done pulses", run), 1, dones);
         foreach (exp_val[k])
            assert (tile_i.mem[exp_addr[k]] == exp_val[k])
               else report_mismatch($sformatf("run%0d %s", run, exp_name[k]), exp_val[k],
                                    tile_i.mem[exp_addr[k]]);
      end
      if (dut_i.port_chk_i.fail_cnt == 0) begin
         $display("All tests passed!");
         $finish;
      end else begin
         fail_stop("a port protocol assertion failed");
      end
   end

   always @(posedge dclk) begin
      cycles++;
      if (cycles > MAX_CYC)
         fail_stop($sformatf("timeout after %0d cycles", cycles));
      else if (dut_i.port_chk_i.fail_cnt != 0)
         fail_stop("a port protocol assertion failed");
   end

endmodule

`default_nettype wire

// File: verilog.f
hdl/reconfig_pkg.sv
hdl/counter_encoder.sv
hdl/drp_step_table.sv
hdl/drp_sequencer.sv
hdl/clk_reconfig_top.sv
verif/drp_port_asserts.sv
verif/drp_tile_model.sv
verif/tb_clk_reconfig.sv
